// File: design/decompress_pkg.sv
// ***********************************************************
// Shared widths, the compression mode type and the memory
// request and response structs of the decompression subsystem.
// Modules import it inside their bodies.
// ***********************************************************
package decompress_pkg;

    localparam int COEFF_PER_CLK = 4;
    localparam int COEFF_W       = 12;
    localparam int Q_MOD         = 3329;
    localparam int POLY_N        = 256;
    localparam int API_DATA_W    = 64;
    localparam int MEM_ADDR_W    = 8;

    // Compression width d of the packed API stream
    typedef enum logic [1:0] {
        MODE_D1  = 2'd0,
        MODE_D5  = 2'd1,
        MODE_D11 = 2'd2,
        MODE_D12 = 2'd3
    } decomp_mode_t;

    typedef logic [COEFF_PER_CLK-1:0][COEFF_W-1:0] mem_word_t;

    typedef struct packed {
        logic                  wr;
        logic [MEM_ADDR_W-1:0] addr;
        mem_word_t             data;
    } mem_req_t;

    typedef struct packed {
        logic      valid;
        mem_word_t data;
    } mem_rsp_t;

    function automatic logic [3:0] mode_bits(decomp_mode_t mode);
        case (mode)
            MODE_D1:  return 4'd1;
            MODE_D5:  return 4'd5;
            MODE_D11: return 4'd11;
            default:  return 4'd12;
        endcase
    endfunction

    // Bits taken from the PISO per cycle, one d-bit code per coefficient
    function automatic logic [6:0] mode_out_bits(decomp_mode_t mode);
        return 7'(COEFF_PER_CLK * mode_bits(mode));
    endfunction

endpackage

// File: design/coeff_piso.sv
`timescale 1ns/10ps
// ***********************************************************
// Multi-rate bit buffer. Takes 64-bit API words and gives out
// four d-bit codes per cycle, oldest bits in the low end.
// hold_o stops the producer, hold_i stops the output.
// ***********************************************************
module coeff_piso (
    input  logic                                                     clk,
    input  logic                                                     reset_n,
    input  logic                                                     zeroize_i,
    input  decompress_pkg::decomp_mode_t                             mode_i,
    input  logic                                                     valid_i,
    input  logic [decompress_pkg::API_DATA_W-1:0]                    data_i,
    output logic                                                     hold_o,
    input  logic                                                     hold_i,
    output logic                                                     valid_o,
    output logic [decompress_pkg::COEFF_PER_CLK*decompress_pkg::COEFF_W-1:0] data_o
);
    import decompress_pkg::*;

    localparam int BUF_W  = 112;
    localparam int FILL_W = $clog2(BUF_W + 1);

    logic [BUF_W-1:0]  buf_q;
    logic [BUF_W-1:0]  buf_shift;
    logic [BUF_W-1:0]  buf_in;
    logic [FILL_W-1:0] fill_q;
    logic [FILL_W-1:0] fill_shift;
    logic [6:0]        out_bits;

    assign out_bits = mode_out_bits(mode_i);

    // No room for another full API word
    assign hold_o  = (int'(fill_q) + API_DATA_W) > BUF_W;
    assign valid_o = (fill_q >= out_bits) & ~hold_i;
    assign data_o  = buf_q[COEFF_PER_CLK*COEFF_W-1:0];

    always_comb begin
        buf_shift  = valid_o ? (buf_q >> out_bits) : buf_q;
        fill_shift = valid_o ? (fill_q - out_bits) : fill_q;
        // New word lands just above the bits still held
        buf_in     = {{(BUF_W-API_DATA_W){1'b0}}, data_i} << fill_shift;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            buf_q  <= '0;
            fill_q <= '0;
        end else if (zeroize_i) begin
            buf_q  <= '0;
            fill_q <= '0;
        end else if (valid_i) begin
            buf_q  <= buf_shift | buf_in;
            fill_q <= fill_shift + FILL_W'(API_DATA_W);
        end else begin
            buf_q  <= buf_shift;
            fill_q <= fill_shift;
        end
    end

    // The engine parks a late read word instead of pushing it into a full buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        valid_i |-> (int'(fill_q) + API_DATA_W) <= BUF_W);

endmodule

// File: design/coeff_decompress.sv
`timescale 1ns/10ps
// ***********************************************************
// Decompression of one coefficient, round(x * q / 2^d).
// Combinational. In the 12-bit mode the code passes unchanged.
// ***********************************************************
module coeff_decompress (
    input  logic [decompress_pkg::COEFF_W-1:0] code_i,
    input  decompress_pkg::decomp_mode_t       mode_i,
    output logic [decompress_pkg::COEFF_W-1:0] coeff_o
);
    import decompress_pkg::*;

    logic [3:0]         d;
    logic [COEFF_W-1:0] code_m;
    logic [24:0]        scaled;

    always_comb begin
        d      = mode_bits(mode_i);
        code_m = code_i & ((COEFF_W'(1) << d) - COEFF_W'(1));
        // Half of 2^d added before the shift rounds to nearest
        scaled = (25'(code_m) * 25'(Q_MOD) + (25'd1 << (d - 4'd1))) >> d;
        if (mode_i == MODE_D12) begin
            coeff_o = code_i;
        end else begin
            coeff_o = scaled[COEFF_W-1:0];
        end
    end

endmodule

// File: design/decompress_engine.sv
`timescale 1ns/10ps
// ***********************************************************
// Decompression sequencer. Reads packed words from the API
// buffer, unpacks them through the PISO, decompresses four
// coefficients per cycle and writes them as credited requests.
// ***********************************************************
module decompress_engine #(
    parameter int CREDITS = 2
) (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  zeroize_i,
    input  logic                                  start_i,
    input  decompress_pkg::decomp_mode_t          mode_i,
    input  logic [2:0]                            num_poly_i,
    input  logic [decompress_pkg::MEM_ADDR_W-1:0] src_base_i,
    input  logic [decompress_pkg::MEM_ADDR_W-1:0] dest_base_i,
    output logic                                  api_rd_en_o,
    output logic [decompress_pkg::MEM_ADDR_W-1:0] api_rd_addr_o,
    input  logic [decompress_pkg::API_DATA_W-1:0] api_rd_data_i,
    output logic                                  wr_valid_o,
    output decompress_pkg::mem_req_t              wr_req_o,
    input  logic                                  wr_credit_i,
    output logic                                  done_o
);
    import decompress_pkg::*;

    localparam int CRD_W       = $clog2(CREDITS + 1);
    localparam int WR_PER_POLY = POLY_N / COEFF_PER_CLK;

    logic                                   busy_q;
    decomp_mode_t                           mode_q;
    logic [2:0]                             num_poly_q;
    logic [3:0]                             d;
    logic [7:0]                             rd_total;
    logic [8:0]                             wr_total;
    logic [MEM_ADDR_W-1:0]                  rd_addr_q;
    logic [MEM_ADDR_W-1:0]                  wr_addr_q;
    logic [7:0]                             rd_cnt_q;
    logic [8:0]                             ack_cnt_q;
    logic [CRD_W-1:0]                       credit_cnt_q;
    logic                                   last_ack;
    logic                                   done_q;
    logic                                   rd_vld_q;
    logic                                   pend_valid_q;
    logic [API_DATA_W-1:0]                  pend_data_q;
    logic                                   piso_valid_i;
    logic [API_DATA_W-1:0]                  piso_data_i;
    logic                                   piso_hold;
    logic [COEFF_PER_CLK*COEFF_W-1:0]       piso_data;
    logic [COEFF_PER_CLK-1:0][COEFF_W-1:0]  codes;
    mem_word_t                              coeffs;

    assign d        = mode_bits(mode_q);
    // Each polynomial packs 256 codes of d bits into 4*d API words
    assign rd_total = 8'(int'(num_poly_q) * POLY_N * int'(d) / API_DATA_W);
    assign wr_total = 9'(int'(num_poly_q) * WR_PER_POLY);

    assign api_rd_en_o   = busy_q & (rd_cnt_q != rd_total) & ~piso_hold & ~pend_valid_q;
    assign api_rd_addr_o = rd_addr_q;
    assign last_ack      = busy_q & wr_credit_i & (ack_cnt_q == wr_total - 9'd1);
    assign done_o        = done_q;

    // A word parked during hold goes first and never coincides with a fresh one
    assign piso_valid_i = (rd_vld_q | pend_valid_q) & ~piso_hold;
    assign piso_data_i  = pend_valid_q ? pend_data_q : api_rd_data_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q       <= 1'b0;
            mode_q       <= MODE_D1;
            num_poly_q   <= '0;
            rd_addr_q    <= '0;
            wr_addr_q    <= '0;
            rd_cnt_q     <= '0;
            ack_cnt_q    <= '0;
            credit_cnt_q <= CRD_W'(CREDITS);
            done_q       <= 1'b0;
            rd_vld_q     <= 1'b0;
            pend_valid_q <= 1'b0;
        end else if (zeroize_i) begin
            busy_q       <= 1'b0;
            mode_q       <= MODE_D1;
            num_poly_q   <= '0;
            rd_addr_q    <= '0;
            wr_addr_q    <= '0;
            rd_cnt_q     <= '0;
            ack_cnt_q    <= '0;
            credit_cnt_q <= CRD_W'(CREDITS);
            done_q       <= 1'b0;
            rd_vld_q     <= 1'b0;
            pend_valid_q <= 1'b0;
        end else begin
            if (start_i) begin
                busy_q     <= 1'b1;
                mode_q     <= mode_i;
                num_poly_q <= num_poly_i;
                rd_addr_q  <= src_base_i;
                wr_addr_q  <= dest_base_i;
                rd_cnt_q   <= '0;
                ack_cnt_q  <= '0;
            end else begin
                if (last_ack) begin
                    busy_q <= 1'b0;
                end
                if (api_rd_en_o) begin
                    rd_addr_q <= rd_addr_q + 1'b1;
                    rd_cnt_q  <= rd_cnt_q + 8'd1;
                end
                if (wr_valid_o) begin
                    wr_addr_q <= wr_addr_q + 1'b1;
                end
                if (busy_q && wr_credit_i) begin
                    ack_cnt_q <= ack_cnt_q + 9'd1;
                end
            end
            credit_cnt_q <= credit_cnt_q - CRD_W'(wr_valid_o) + CRD_W'(wr_credit_i);
            done_q       <= last_ack;
            rd_vld_q     <= api_rd_en_o;
            pend_valid_q <= (rd_vld_q | pend_valid_q) & piso_hold;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_vld_q && piso_hold) begin
            pend_data_q <= api_rd_data_i;
        end
    end

    coeff_piso u_piso (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_q),
        .valid_i   (piso_valid_i),
        .data_i    (piso_data_i),
        .hold_o    (piso_hold),
        .hold_i    (credit_cnt_q == '0),
        .valid_o   (wr_valid_o),
        .data_o    (piso_data)
    );

    // Code i sits at bit i*d of the PISO output
    always_comb begin
        for (int i = 0; i < COEFF_PER_CLK; i++) begin
            codes[i] = COEFF_W'(piso_data >> (i * int'(d)));
        end
    end

    for (genvar i = 0; i < COEFF_PER_CLK; i++) begin : g_decomp
        coeff_decompress u_decomp (
            .code_i  (codes[i]),
            .mode_i  (mode_q),
            .coeff_o (coeffs[i])
        );
    end

    always_comb begin
        wr_req_o.wr   = 1'b1;
        wr_req_o.addr = wr_addr_q;
        wr_req_o.data = coeffs;
    end

    // A credit only comes back for a write still in flight
    a_credit_return: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        wr_credit_i |-> credit_cnt_q != CRD_W'(CREDITS));

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/10ps
// ***********************************************************
// Two-client round-robin arbiter in front of the polynomial
// memory. Each client has a FIFO of CREDITS entries and gets a
// credit back on the cycle its request is granted.
// ***********************************************************
module mem_arbiter #(
    parameter int CREDITS = 2
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize_i,
    input  logic [1:0]                     req_valid_i,
    input  decompress_pkg::mem_req_t [1:0] req_i,
    output logic [1:0]                     credit_o,
    output logic                           mem_en_o,
    output decompress_pkg::mem_req_t       mem_req_o
);
    import decompress_pkg::*;

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);

    mem_req_t [1:0] head;
    logic [1:0]     not_empty;
    logic [1:0]     grant;
    // Client 1 wins a tie when set
    logic           prio_q;

    for (genvar c = 0; c < 2; c++) begin : g_fifo
        mem_req_t         slot_q [CREDITS];
        logic [PTR_W-1:0] wr_ptr_q;
        logic [PTR_W-1:0] rd_ptr_q;
        logic [CNT_W-1:0] cnt_q;

        always_ff @(posedge clk) begin
            if (req_valid_i[c]) begin
                slot_q[wr_ptr_q] <= req_i[c];
            end
        end

        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                cnt_q    <= '0;
            end else if (zeroize_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                cnt_q    <= '0;
            end else begin
                if (req_valid_i[c]) begin
                    wr_ptr_q <= (wr_ptr_q == PTR_W'(CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
                end
                if (grant[c]) begin
                    rd_ptr_q <= (rd_ptr_q == PTR_W'(CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
                end
                cnt_q <= cnt_q + CNT_W'(req_valid_i[c]) - CNT_W'(grant[c]);
            end
        end

        assign not_empty[c] = (cnt_q != '0);
        assign head[c]      = slot_q[rd_ptr_q];

        // A full FIFO means the client sent without holding a credit
        a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
            req_valid_i[c] |-> cnt_q != CNT_W'(CREDITS));
    end

    assign grant[1]  = not_empty[1] & (~not_empty[0] | prio_q);
    assign grant[0]  = not_empty[0] & ~grant[1];
    assign credit_o  = grant;
    assign mem_en_o  = |grant;
    assign mem_req_o = grant[1] ? head[1] : head[0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prio_q <= 1'b0;
        end else if (zeroize_i) begin
            prio_q <= 1'b0;
        end else if (grant[0]) begin
            prio_q <= 1'b1;
        end else if (grant[1]) begin
            prio_q <= 1'b0;
        end
    end

endmodule

// File: design/poly_mem.sv
`timescale 1ns/10ps
// ***********************************************************
// Single-port polynomial memory. Writes on a granted write,
// returns read data one cycle after a granted read.
// ***********************************************************
module poly_mem #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     en_i,
    input  decompress_pkg::mem_req_t req_i,
    output decompress_pkg::mem_rsp_t rsp_o
);
    import decompress_pkg::*;

    mem_word_t mem_q [MEM_DEPTH];
    mem_word_t rd_data_q;
    logic      rd_valid_q;

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (req_i.wr) begin
                mem_q[req_i.addr] <= req_i.data;
            end else begin
                rd_data_q <= mem_q[req_i.addr];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= en_i & ~req_i.wr;
        end
    end

    assign rsp_o.valid = rd_valid_q;
    assign rsp_o.data  = rd_data_q;

endmodule

// File: design/decompress_top.sv
`timescale 1ns/10ps
// ***********************************************************
// Top level of the decompression subsystem. The engine and the
// host port share the polynomial memory through the arbiter,
// engine on client 0 and host on client 1.
// ***********************************************************
module decompress_top #(
    parameter int CREDITS   = 2,
    parameter int MEM_DEPTH = 256
) (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  zeroize_i,
    input  logic                                  start_i,
    input  decompress_pkg::decomp_mode_t          mode_i,
    input  logic [2:0]                            num_poly_i,
    input  logic [decompress_pkg::MEM_ADDR_W-1:0] src_base_i,
    input  logic [decompress_pkg::MEM_ADDR_W-1:0] dest_base_i,
    output logic                                  api_rd_en_o,
    output logic [decompress_pkg::MEM_ADDR_W-1:0] api_rd_addr_o,
    input  logic [decompress_pkg::API_DATA_W-1:0] api_rd_data_i,
    input  logic                                  host_req_valid_i,
    input  decompress_pkg::mem_req_t              host_req_i,
    output logic                                  host_credit_o,
    output decompress_pkg::mem_rsp_t              host_rsp_o,
    output logic                                  done_o
);
    import decompress_pkg::*;

    logic           eng_wr_valid;
    mem_req_t       eng_wr_req;
    logic [1:0]     arb_valid;
    mem_req_t [1:0] arb_req;
    logic [1:0]     arb_credit;
    logic           mem_en;
    mem_req_t       mem_req;

    assign arb_valid     = {host_req_valid_i, eng_wr_valid};
    assign arb_req       = {host_req_i, eng_wr_req};
    assign host_credit_o = arb_credit[1];

    decompress_engine #(.CREDITS(CREDITS)) u_engine (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .start_i       (start_i),
        .mode_i        (mode_i),
        .num_poly_i    (num_poly_i),
        .src_base_i    (src_base_i),
        .dest_base_i   (dest_base_i),
        .api_rd_en_o   (api_rd_en_o),
        .api_rd_addr_o (api_rd_addr_o),
        .api_rd_data_i (api_rd_data_i),
        .wr_valid_o    (eng_wr_valid),
        .wr_req_o      (eng_wr_req),
        .wr_credit_i   (arb_credit[0]),
        .done_o        (done_o)
    );

    mem_arbiter #(.CREDITS(CREDITS)) u_arbiter (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .req_valid_i (arb_valid),
        .req_i       (arb_req),
        .credit_o    (arb_credit),
        .mem_en_o    (mem_en),
        .mem_req_o   (mem_req)
    );

    // Only the host reads, so read data goes straight back to it
    poly_mem #(.MEM_DEPTH(MEM_DEPTH)) u_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .en_i    (mem_en),
        .req_i   (mem_req),
        .rsp_o   (host_rsp_o)
    );

endmodule

// File: verification/tb_decompress_top.sv
`timescale 1ns/10ps
// ***********************************************************
// Directed testbench of the decompression subsystem. Models the
// API buffer and a credited host client, derives the expected
// memory contents from the packed bitstream, runs five tests.
// ***********************************************************
module tb_decompress_top;
    import decompress_pkg::*;

    localparam int CREDITS     = 2;
    localparam int CMD_TIMEOUT = 2000;
    // Rough cycle budget of each test
    localparam int TEST_CYCLES = 1100 + 900 + 800 + 600 + 800;
    // Watchdog allows four times the sum
    localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic                  zeroize_i;
    logic                  start_i;
    decomp_mode_t          mode_i;
    logic [2:0]            num_poly_i;
    logic [MEM_ADDR_W-1:0] src_base_i;
    logic [MEM_ADDR_W-1:0] dest_base_i;
    logic                  api_rd_en_o;
    logic [MEM_ADDR_W-1:0] api_rd_addr_o;
    logic [API_DATA_W-1:0] api_rd_data_i;
    logic                  host_req_valid_i;
    mem_req_t              host_req_i;
    logic                  host_credit_o;
    mem_rsp_t              host_rsp_o;
    logic                  done_o;

    logic [API_DATA_W-1:0] api_mem [256];
    mem_word_t             shadow [256];
    bit                    known [256];
    int                    api_addr_q [$];
    mem_rsp_t              exp_q [$];
    int                    exp_addr_q [$];
    int                    hcred;
    int                    credit_total;
    int                    errors = 0;

    always #10 clk = ~clk;

    decompress_top #(.CREDITS(CREDITS), .MEM_DEPTH(256)) uut (.*);

    // API buffer answers one cycle after the read enable
    always @(posedge clk) begin
        if (api_rd_en_o) begin
            api_rd_data_i <= api_mem[api_rd_addr_o];
            api_addr_q.push_back(int'(api_rd_addr_o));
        end
    end

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hcred        <= CREDITS;
            credit_total <= 0;
        end else begin
            hcred        <= hcred - int'(host_req_valid_i) + int'(host_credit_o);
            credit_total <= credit_total + int'(host_credit_o);
        end
    end

    // Host read data comes back in request order
    always @(posedge clk) begin
        if (reset_n && host_rsp_o.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Host response arrived with no read outstanding");
            end else begin
                check_rsp($sformatf("host_rsp_o[%02h]", exp_addr_q.pop_front()),
                          host_rsp_o, exp_q.pop_front());
            end
        end
    end

    task automatic check_word(input string name, input mem_word_t got, input mem_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_rsp(input string name, input mem_rsp_t got, input mem_rsp_t exp);
        if (got.valid !== exp.valid) begin
            errors++;
            $display("ERROR %s.valid: got %h expected %h", name, got.valid, exp.valid);
        end else if (exp.valid) begin
            check_word({name, ".data"}, got.data, exp.data);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic int code_width(input decomp_mode_t mode);
        case (mode)
            MODE_D1:  return 1;
            MODE_D5:  return 5;
            MODE_D11: return 11;
            default:  return 12;
        endcase
    endfunction

    // Code n of the stream starts at bit n*d, low bits of each word first
    function automatic int code_at(input int src, input int d, input int n);
        int value = 0;
        int pos;
        for (int b = 0; b < d; b++) begin
            pos = n * d + b;
            value |= int'(api_mem[(src + pos / 64) % 256][pos % 64]) << b;
        end
        return value;
    endfunction

    function automatic mem_word_t expected_word(input int src, input int d, input int w);
        mem_word_t e;
        int        code;
        int        prod;
        int        quot;
        for (int i = 0; i < 4; i++) begin
            code = code_at(src, d, 4 * w + i);
            prod = code * 3329;
            quot = prod / (1 << d);
            // Round to nearest, halves go up
            if (2 * (prod % (1 << d)) >= (1 << d)) begin
                quot++;
            end
            e[i] = (d == 12) ? 12'(code) : 12'(quot);
        end
        return e;
    endfunction

    task automatic host_send(input mem_req_t req);
        @(posedge clk);
        while (hcred - int'(host_req_valid_i) + int'(host_credit_o) == 0) begin
            @(posedge clk);
        end
        host_req_valid_i <= 1'b1;
        host_req_i       <= req;
        @(posedge clk);
        host_req_valid_i <= 1'b0;
    endtask

    task automatic host_write(input int addr, input mem_word_t w);
        mem_req_t req;
        req.wr       = 1'b1;
        req.addr     = 8'(addr);
        req.data     = w;
        shadow[addr] = w;
        known[addr]  = 1'b1;
        host_send(req);
    endtask

    task automatic host_read(input int addr);
        mem_req_t req;
        mem_rsp_t exp;
        req.wr    = 1'b0;
        req.addr  = 8'(addr);
        req.data  = '0;
        exp.valid = 1'b1;
        exp.data  = shadow[addr];
        exp_q.push_back(exp);
        exp_addr_q.push_back(addr);
        host_send(req);
    endtask

    task automatic wait_host_idle();
        int n = 0;
        while ((exp_q.size() != 0 || hcred != CREDITS) && n < 1000) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0 || hcred != CREDITS) begin
            errors++;
            $display("Host reads or credits still outstanding after %0d cycles", n);
        end
    endtask

    task automatic verify_region(input int base, input int count);
        for (int a = 0; a < count; a++) begin
            if (known[(base + a) % 256]) begin
                host_read((base + a) % 256);
            end
        end
        wait_host_idle();
    endtask

    task automatic start_command(input decomp_mode_t mode, input int npoly,
                                 input int src, input int dest);
        @(posedge clk);
        start_i     <= 1'b1;
        mode_i      <= mode;
        num_poly_i  <= 3'(npoly);
        src_base_i  <= 8'(src);
        dest_base_i <= 8'(dest);
        @(posedge clk);
        start_i <= 1'b0;
    endtask

    task automatic run_command(input decomp_mode_t mode, input int npoly,
                               input int src, input int dest);
        int cycles = 0;
        int d;
        d = code_width(mode);
        start_command(mode, npoly, src, dest);
        do begin
            @(posedge clk);
            cycles++;
        end while (!done_o && cycles < CMD_TIMEOUT);
        if (!done_o) begin
            errors++;
            $display("done_o did not pulse within %0d cycles", CMD_TIMEOUT);
        end else begin
            @(posedge clk);
            check_bit("done_o", done_o, 1'b0);
            for (int w = 0; w < npoly * 64; w++) begin
                shadow[(dest + w) % 256] = expected_word(src, d, w);
                known[(dest + w) % 256]  = 1'b1;
            end
        end
    endtask

    task automatic test_each_mode();
        decomp_mode_t modes [4] = '{MODE_D1, MODE_D5, MODE_D11, MODE_D12};
        for (int m = 0; m < 4; m++) begin
            run_command(modes[m], 1, 8 * m, 0);
            verify_region(0, 64);
        end
    endtask

    task automatic test_four_poly();
        run_command(MODE_D11, 4, 8'h40, 8'h10);
        verify_region(0, 256);
    endtask

    task automatic test_host_traffic();
        int cred0 = credit_total;
        logic [63:0] r;
        fork
            run_command(MODE_D5, 2, 8'h10, 8'h00);
            begin
                for (int a = 8'hC0; a < 8'hD0; a++) begin
                    r = {$urandom, $urandom};
                    host_write(a, r[47:0]);
                end
                for (int a = 8'hC0; a < 8'hD0; a++) begin
                    host_read(a);
                end
            end
        join
        wait_host_idle();
        // Sixteen writes and sixteen reads were sent by the host
        check_count("host_credit_o pulses", credit_total - cred0, 32);
        verify_region(0, 128);
    endtask

    task automatic test_held_stream();
        api_addr_q.delete();
        fork
            run_command(MODE_D12, 2, 8'h20, 8'h80);
            verify_region(0, 64);
        join
        check_count("api read count", api_addr_q.size(), 2 * 4 * 12);
        for (int i = 0; i < api_addr_q.size(); i++) begin
            check_count($sformatf("api_rd_addr_o #%0d", i), api_addr_q[i], 8'h20 + i);
        end
        verify_region(8'h80, 128);
    endtask

    task automatic test_zeroize();
        bit seen = 1'b0;
        start_command(MODE_D11, 1, 8'h00, 8'h40);
        repeat (20) @(posedge clk);
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
        @(posedge clk);
        check_bit("api_rd_en_o", api_rd_en_o, 1'b0);
        check_bit("done_o", done_o, 1'b0);
        check_bit("host_credit_o", host_credit_o, 1'b0);
        repeat (100) begin
            @(posedge clk);
            seen |= done_o;
        end
        if (seen) begin
            errors++;
            $display("done_o pulsed for a command that was zeroized");
        end
        run_command(MODE_D11, 1, 8'h00, 8'h40);
        // Whole memory, so words outside the new range are checked as well
        verify_region(0, 256);
    endtask

    initial begin
        reset_n          = 1'b0;
        zeroize_i        = 1'b0;
        start_i          = 1'b0;
        mode_i           = MODE_D1;
        num_poly_i       = '0;
        src_base_i       = '0;
        dest_base_i      = '0;
        api_rd_data_i    = '0;
        host_req_valid_i = 1'b0;
        host_req_i       = '0;
        void'($urandom(32'h651555dc));
        for (int a = 0; a < 256; a++) begin
            api_mem[a] = {$urandom, $urandom};
            known[a]   = 1'b0;
        end
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        check_bit("api_rd_en_o", api_rd_en_o, 1'b0);
        check_bit("done_o", done_o, 1'b0);
        check_bit("host_credit_o", host_credit_o, 1'b0);
        check_rsp("host_rsp_o", host_rsp_o, '0);
        test_each_mode();
        test_four_poly();
        test_host_traffic();
        test_held_stream();
        test_zeroize();
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with %0d errors", WATCHDOG_CYCLES, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: project.f
design/decompress_pkg.sv
design/coeff_piso.sv
design/coeff_decompress.sv
design/decompress_engine.sv
design/mem_arbiter.sv
design/poly_mem.sv
design/decompress_top.sv
verification/tb_decompress_top.sv
